// File: files.f
verilog/trdb_pkg.sv
verilog/trdb_instr_pair.sv
verilog/trdb_itype_detector.sv
verilog/trdb_addr_filter.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_apb_regs.sv
verilog/trdb_top.sv
tests/trdb_tb.sv

// File: tests/trdb_tb.sv
// self-checking testbench for the trace encoder top, compares packets with a model
// LFSR stimulus with a fixed seed; APB is idle while instructions stream
`timescale 1ns/1ps

module trdb_tb;

    localparam int N_QUIET  = 200;
    localparam int N_BRANCH = 800;
    localparam int N_MIXED  = 1500;
    localparam int N_NARROW = 1500;
    // three directed sequences of 34 instructions
    localparam int N_TOTAL  = 3 * N_QUIET + N_BRANCH + N_MIXED + N_NARROW + 3 * 34;
    localparam int MARGIN   = 1500;
    localparam trdb_pkg::iaddr_t BASE = 32'h1000_0000;
    localparam logic [31:0]      SPAN = 32'h0000_07fe;

    logic               clk;
    logic               arst_n;
    logic               valid;
    trdb_pkg::retired_t retired;
    trdb_pkg::apb_req_t apb_req;
    trdb_pkg::apb_rsp_t apb_rsp;
    logic               pkt_valid;
    trdb_pkg::packet_t  pkt;

    // expected packets in emission order
    trdb_pkg::packet_t exp_q[$];
    string             test_name;
    int                mismatch_cnt;
    int                other_err_cnt;
    logic [31:0]       lfsr_q;

    // model of pair, emitter and registers
    trdb_pkg::retired_t m_tc;
    trdb_pkg::retired_t m_nc;
    logic               m_tc_rdy;
    logic               m_nc_rdy;
    logic               m_pending;
    trdb_pkg::map_t     m_map;
    int                 m_cnt;
    trdb_pkg::iaddr_t   m_lo;
    trdb_pkg::iaddr_t   m_hi;
    logic               m_enable;
    int                 m_pkt_cnt;

    // last driven instruction, for sequential addresses and repeats
    trdb_pkg::retired_t g_prev;
    logic               g_prev_br;
    logic               g_prev_jalr;
    logic               g_have_prev;

    trdb_top #(
        .PKT_CNT_W (16)
    ) dut_i (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .valid_i     (valid),
        .retired_i   (retired),
        .apb_i       (apb_req),
        .apb_o       (apb_rsp),
        .pkt_valid_o (pkt_valid),
        .pkt_o       (pkt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic void push_packet(input trdb_pkg::pkt_fmt_e fmt,
                                        input trdb_pkg::iaddr_t addr);
        trdb_pkg::packet_t p;
        p = '{fmt: fmt, bcnt: trdb_pkg::bcnt_t'(m_cnt), map: m_map, iaddr: addr};
        exp_q.push_back(p);
        m_pkt_cnt++;
        // every packet starts a fresh map
        m_map = '0;
        m_cnt = 0;
    endfunction

    // packet rules, applied once per accepted instruction
    function automatic void predict_packets(input trdb_pkg::retired_t r, input logic is_br,
                                            input logic is_jalr);
        logic             taken;
        logic             in_win;
        trdb_pkg::iaddr_t seq;
        m_tc     = m_nc;
        m_tc_rdy = m_nc_rdy;
        m_nc     = r;
        m_nc_rdy = 1'b1;
        // same address twice adds nothing
        if (m_tc_rdy && m_tc.iaddr == m_nc.iaddr) begin
            return;
        end
        seq    = m_tc.iaddr + (m_tc.compressed ? 32'd2 : 32'd4);
        taken  = m_tc_rdy && (m_nc.iaddr != seq);
        in_win = (m_nc.iaddr >= m_lo) && (m_nc.iaddr <= m_hi);
        // verdict of the previous in-window branch
        if (m_pending && m_tc_rdy) begin
            m_map[m_cnt] = taken;
            m_cnt++;
        end
        if (m_cnt == trdb_pkg::MAP_LEN) begin
            push_packet(trdb_pkg::PKT_BRANCH_FULL, m_tc.iaddr);
        end
        if ((is_jalr || r.exception) && in_win) begin
            push_packet(trdb_pkg::PKT_DISCON, m_nc.iaddr);
        end
        m_pending = is_br && in_win;
    endfunction

    task automatic check_field(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
            mismatch_cnt++;
        end
    endtask

    // outputs sampled mid-cycle, away from the edges
    always @(negedge clk) begin : compare_packets
        trdb_pkg::packet_t exp;
        if (arst_n && pkt_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: packet at %h emitted while none was expected",
                         test_name, pkt.iaddr);
                other_err_cnt++;
            end else begin
                exp = exp_q.pop_front();
                check_field("fmt", 32'(exp.fmt), 32'(pkt.fmt));
                check_field("bcnt", 32'(exp.bcnt), 32'(pkt.bcnt));
                check_field("map", 32'(exp.map), 32'(pkt.map));
                check_field("iaddr", exp.iaddr, pkt.iaddr);
            end
        end
    end

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // response is valid during the access cycle
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // no wait states, pready high in every access cycle
        if (apb_rsp.pready !== 1'b1) begin
            $display("MISMATCH %s pready at %h: expected 1 actual %b",
                     test_name, addr, apb_rsp.pready);
            mismatch_cnt++;
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        if (err !== exp_err) begin
            $display("MISMATCH %s pslverr on write to %h: expected %b actual %b",
                     test_name, addr, exp_err, err);
            mismatch_cnt++;
        end
        if (!exp_err) begin
            case (addr)
                trdb_pkg::REG_CTRL: begin
                    m_enable = data[0];
                    // disabling empties both slots
                    if (!data[0]) begin
                        m_tc_rdy = 1'b0;
                        m_nc_rdy = 1'b0;
                    end
                    if (data[1]) begin
                        m_pkt_cnt = 0;
                    end
                end
                trdb_pkg::REG_WIN_LO: m_lo = data;
                trdb_pkg::REG_WIN_HI: m_hi = data;
                default: ;
            endcase
        end
    endtask

    task automatic reg_read(input logic [3:0] addr, input logic [31:0] exp,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        if (err !== exp_err) begin
            $display("MISMATCH %s pslverr on read of %h: expected %b actual %b",
                     test_name, addr, exp_err, err);
            mismatch_cnt++;
        end
        if (!exp_err) begin
            check_field($sformatf("read of %h", addr), exp, rdata);
        end
    endtask

    task automatic drive_insn(input trdb_pkg::retired_t r, input logic is_br,
                              input logic is_jalr);
        @(posedge clk);
        valid   <= 1'b1;
        retired <= r;
        if (m_enable) begin
            predict_packets(r, is_br, is_jalr);
        end
        g_prev      = r;
        g_prev_br   = is_br;
        g_prev_jalr = is_jalr;
        g_have_prev = 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        valid <= 1'b0;
    endtask

    // wait for expected packets, then a few cycles for strays
    task automatic drain();
        int waited;
        idle_cycle();
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic send_random(input int n, input logic branch_only,
                               input trdb_pkg::iaddr_t base, input logic [31:0] span);
        trdb_pkg::retired_t r;
        logic [31:0]        rnd;
        logic [2:0]         kind;
        logic               is_br;
        logic               is_jalr;
        int                 i;
        for (i = 0; i < n; i++) begin
            if (lfsr_bits(3) == 0) begin
                idle_cycle();
            end else if (!branch_only && g_have_prev && lfsr_bits(5) == 0) begin
                // instruction reported twice
                drive_insn(g_prev, g_prev_br, g_prev_jalr);
            end else begin
                // mostly sequential, one in four jumps
                if (!g_have_prev || lfsr_bits(2) == 0) begin
                    r.iaddr = base + (lfsr_bits(32) & span);
                end else begin
                    r.iaddr = g_prev.iaddr + (g_prev.compressed ? 32'd2 : 32'd4);
                end
                kind         = branch_only ? 3'd0 : 3'(lfsr_bits(3));
                is_br        = kind < 3'd3;
                is_jalr      = kind == 3'd3;
                r.compressed = !is_jalr && lfsr_bits(1);
                rnd          = lfsr_bits(25);
                if (r.compressed) begin
                    // c.beqz/c.bnez, otherwise c.addi
                    r.insn = {16'h0, is_br ? {2'b11, rnd[11]} : 3'b000, rnd[10:0], 2'b01};
                end else if (is_br) begin
                    // any funct3, incl. the immediate branches
                    r.insn = {rnd[24:8], rnd[7:5], rnd[4:0], 7'h63};
                end else begin
                    r.insn = {rnd[24:8], 3'b000, rnd[4:0], is_jalr ? 7'h67 : 7'h13};
                end
                r.exception = !branch_only && lfsr_bits(5) == 0;
                drive_insn(r, is_br, is_jalr);
            end
        end
        idle_cycle();
    endtask

    // jalr, 31 branches, jalr: last update owes a full and a discon packet
    task automatic full_with_discon(input trdb_pkg::iaddr_t base);
        trdb_pkg::retired_t r;
        trdb_pkg::iaddr_t   addr;
        int                 i;
        addr = base;
        r    = '{iaddr: addr, insn: 32'h0000_80e7, compressed: 1'b0, exception: 1'b0};
        drive_insn(r, 1'b0, 1'b1);
        addr = addr + 32'd4;
        for (i = 0; i < trdb_pkg::MAP_LEN; i++) begin
            r = '{iaddr: addr, insn: 32'h00b5_1463, compressed: 1'b0, exception: 1'b0};
            drive_insn(r, 1'b1, 1'b0);
            addr = addr + (lfsr_bits(1) ? 32'd16 : 32'd4);
        end
        r = '{iaddr: addr, insn: 32'h0000_80e7, compressed: 1'b0, exception: 1'b0};
        drive_insn(r, 1'b0, 1'b1);
        r = '{iaddr: addr + 32'h40, insn: 32'h0000_0013, compressed: 1'b0, exception: 1'b0};
        drive_insn(r, 1'b0, 1'b0);
        idle_cycle();
    endtask

    initial begin
        valid         = 1'b0;
        retired       = '0;
        apb_req       = '0;
        arst_n        = 1'b0;
        lfsr_q        = 32'h140b_581e;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        m_tc          = '0;
        m_nc          = '0;
        m_tc_rdy      = 1'b0;
        m_nc_rdy      = 1'b0;
        m_pending     = 1'b0;
        m_map         = '0;
        m_cnt         = 0;
        m_lo          = '0;
        m_hi          = '1;
        m_enable      = 1'b0;
        m_pkt_cnt     = 0;
        g_prev        = '0;
        g_prev_br     = 1'b0;
        g_prev_jalr   = 1'b0;
        g_have_prev   = 1'b0;
        test_name     = "reset";
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // reset values, then input while disabled
        reg_read(trdb_pkg::REG_CTRL, 32'h0, 1'b0);
        reg_read(trdb_pkg::REG_WIN_LO, 32'h0, 1'b0);
        reg_read(trdb_pkg::REG_WIN_HI, 32'hffff_ffff, 1'b0);
        reg_read(trdb_pkg::REG_PKT_CNT, 32'h0, 1'b0);
        send_random(N_QUIET, 1'b0, BASE, SPAN);
        drain();
        reg_read(trdb_pkg::REG_PKT_CNT, 32'h0, 1'b0);

        test_name = "regs";
        reg_write(trdb_pkg::REG_WIN_LO, 32'h1000_0000, 1'b0);
        reg_read(trdb_pkg::REG_WIN_LO, 32'h1000_0000, 1'b0);
        reg_write(trdb_pkg::REG_WIN_HI, 32'h1000_ffff, 1'b0);
        reg_read(trdb_pkg::REG_WIN_HI, 32'h1000_ffff, 1'b0);
        reg_write(4'h2, 32'h5, 1'b1);
        reg_write(trdb_pkg::REG_PKT_CNT, 32'h7, 1'b1);
        reg_read(4'h1, 32'h0, 1'b1);
        reg_write(trdb_pkg::REG_CTRL, 32'h1, 1'b0);
        reg_read(trdb_pkg::REG_CTRL, 32'h1, 1'b0);

        test_name = "branch_only";
        send_random(N_BRANCH, 1'b1, BASE, SPAN);
        drain();

        test_name = "discon";
        send_random(N_MIXED, 1'b0, BASE, SPAN);
        full_with_discon(BASE + 32'h100);
        drain();

        // window covers about half of the address range used
        test_name = "narrow";
        reg_write(trdb_pkg::REG_WIN_LO, 32'h1000_0200, 1'b0);
        reg_write(trdb_pkg::REG_WIN_HI, 32'h1000_05ff, 1'b0);
        send_random(N_NARROW, 1'b0, BASE, SPAN);
        full_with_discon(BASE + 32'h200);
        full_with_discon(BASE + 32'h700);
        drain();

        test_name = "pkt_cnt";
        reg_read(trdb_pkg::REG_PKT_CNT, 32'(m_pkt_cnt), 1'b0);
        reg_write(trdb_pkg::REG_CTRL, 32'h3, 1'b0);
        reg_read(trdb_pkg::REG_PKT_CNT, 32'h0, 1'b0);
        reg_read(trdb_pkg::REG_CTRL, 32'h1, 1'b0);

        // disable, drop input, then resume tracing
        test_name = "restart";
        reg_write(trdb_pkg::REG_CTRL, 32'h0, 1'b0);
        send_random(N_QUIET, 1'b0, BASE, SPAN);
        drain();
        reg_write(trdb_pkg::REG_CTRL, 32'h1, 1'b0);
        send_random(N_QUIET, 1'b0, BASE, SPAN);
        drain();
        reg_read(trdb_pkg::REG_PKT_CNT, 32'(m_pkt_cnt), 1'b0);

        if (exp_q.size() != 0) begin
            $display("%0d expected packets were never emitted", exp_q.size());
            other_err_cnt += exp_q.size();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // one cycle per stimulus step plus room for APB and drains
    initial begin
        #((N_TOTAL + MARGIN) * 20);
        $display("timeout: run did not complete within %0d cycles", N_TOTAL + MARGIN);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_err_cnt);
        $display("test failed");
        $finish;
    end

endmodule

// File: verilog/trdb_top.sv
// trace encoder top, packet output has no back-pressure
// packets appear 2 cycles after the input, 3 for a deferred discon
`timescale 1ns/1ps

module trdb_top #(
    parameter int PKT_CNT_W = 16
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               valid_i,
    input  trdb_pkg::retired_t retired_i,
    input  trdb_pkg::apb_req_t apb_i,
    output trdb_pkg::apb_rsp_t apb_o,
    output logic               pkt_valid_o,
    output trdb_pkg::packet_t  pkt_o
);

    trdb_pkg::pair_t  pair;
    trdb_pkg::itype_t itype;
    trdb_pkg::iaddr_t win_lo;
    trdb_pkg::iaddr_t win_hi;
    logic             update;
    logic             in_window;
    logic             enable;
    logic             pkt_emitted;

    // tc/nc pairing
    trdb_instr_pair pair_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .retired_i (retired_i),
        .enable_i  (enable),
        .pair_o    (pair),
        .update_o  (update)
    );

    // both combinational on the pair
    trdb_itype_detector itype_detector_i (
        .pair_i  (pair),
        .itype_o (itype)
    );

    trdb_addr_filter addr_filter_i (
        .pair_i      (pair),
        .win_lo_i    (win_lo),
        .win_hi_i    (win_hi),
        .in_window_o (in_window)
    );

    trdb_packet_emitter packet_emitter_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .update_i      (update),
        .itype_i       (itype),
        .in_window_i   (in_window),
        .pair_i        (pair),
        .pkt_valid_o   (pkt_valid_o),
        .pkt_o         (pkt_o),
        .pkt_emitted_o (pkt_emitted)
    );

    // software control
    trdb_apb_regs #(
        .PKT_CNT_W (PKT_CNT_W)
    ) apb_regs_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .apb_i         (apb_i),
        .apb_o         (apb_o),
        .pkt_emitted_i (pkt_emitted),
        .enable_o      (enable),
        .win_lo_o      (win_lo),
        .win_hi_o      (win_hi)
    );

endmodule

// File: verilog/trdb_apb_regs.sv
// APB slave, pready tied high so every transfer takes two cycles
// PKT_CNT_W must not exceed 32; ctrl bit 1 clears the counter and reads 0
`timescale 1ns/1ps

module trdb_apb_regs #(
    parameter int PKT_CNT_W = 16
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  trdb_pkg::apb_req_t apb_i,
    output trdb_pkg::apb_rsp_t apb_o,
    input  logic               pkt_emitted_i,
    output logic               enable_o,
    output trdb_pkg::iaddr_t   win_lo_o,
    output trdb_pkg::iaddr_t   win_hi_o
);

    trdb_pkg::apb_state_e state_q;
    logic [PKT_CNT_W-1:0] pkt_cnt_q;
    logic                 access;
    logic                 addr_ok;
    logic                 slv_err;
    logic                 wr_en;
    logic [31:0]          rdata;

    // setup then access phase
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= trdb_pkg::IDLE;
        end else begin
            case (state_q)
                trdb_pkg::IDLE:   if (apb_i.psel && !apb_i.penable) state_q <= trdb_pkg::ACCESS;
                trdb_pkg::ACCESS: state_q <= trdb_pkg::IDLE;
                default:          state_q <= trdb_pkg::IDLE;
            endcase
        end
    end

    assign access = (state_q == trdb_pkg::ACCESS) && apb_i.psel && apb_i.penable;

    // address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (apb_i.paddr)
            trdb_pkg::REG_CTRL:    rdata = {31'b0, enable_o};
            trdb_pkg::REG_WIN_LO:  rdata = win_lo_o;
            trdb_pkg::REG_WIN_HI:  rdata = win_hi_o;
            trdb_pkg::REG_PKT_CNT: rdata = 32'(pkt_cnt_q);
            default:               addr_ok = 1'b0;
        endcase
    end

    // counter is read only
    assign slv_err = access && (!addr_ok ||
                     (apb_i.pwrite && apb_i.paddr == trdb_pkg::REG_PKT_CNT));
    assign wr_en   = access && apb_i.pwrite && !slv_err;

    assign apb_o.prdata  = rdata;
    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = slv_err;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_o  <= 1'b0;
            win_lo_o  <= '0;
            win_hi_o  <= '1;
            pkt_cnt_q <= '0;
        end else begin
            if (wr_en && apb_i.paddr == trdb_pkg::REG_CTRL) begin
                enable_o <= apb_i.pwdata[0];
            end
            if (wr_en && apb_i.paddr == trdb_pkg::REG_WIN_LO) begin
                win_lo_o <= apb_i.pwdata;
            end
            if (wr_en && apb_i.paddr == trdb_pkg::REG_WIN_HI) begin
                win_hi_o <= apb_i.pwdata;
            end
            // clear wins over a packet in the same cycle
            if (wr_en && apb_i.paddr == trdb_pkg::REG_CTRL && apb_i.pwdata[1]) begin
                pkt_cnt_q <= '0;
            end else if (pkt_emitted_i && pkt_cnt_q != '1) begin
                // saturating
                pkt_cnt_q <= pkt_cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: verilog/trdb_packet_emitter.sv
// builds the branch map and emits full and discontinuity packets
// at most one packet per cycle, a second one waits in a one-entry slot
`timescale 1ns/1ps

module trdb_packet_emitter (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              update_i,
    input  trdb_pkg::itype_t  itype_i,
    input  logic              in_window_i,
    input  trdb_pkg::pair_t   pair_i,
    output logic              pkt_valid_o,
    output trdb_pkg::packet_t pkt_o,
    output logic              pkt_emitted_o
);

    logic              pending_q;
    trdb_pkg::map_t    map_q;
    trdb_pkg::bcnt_t   cnt_q;
    logic              slot_valid_q;
    trdb_pkg::packet_t slot_q;

    logic              take;
    logic              append;
    trdb_pkg::map_t    map_upd;
    trdb_pkg::bcnt_t   cnt_upd;
    logic              full_due;
    logic              discon_due;
    trdb_pkg::packet_t full_pkt;
    trdb_pkg::packet_t discon_pkt;
    logic              emit;
    trdb_pkg::packet_t emit_pkt;
    logic              slot_load;

    // repeated address, pair is skipped
    assign take = update_i &&
                  !(pair_i.tc_ready && pair_i.nc_ready && pair_i.tc.iaddr == pair_i.nc.iaddr);
    // verdict for the previous in-window branch is known once tc is valid
    assign append = take && pending_q && pair_i.tc_ready;

    always_comb begin
        map_upd = map_q;
        if (append) begin
            map_upd[cnt_q] = itype_i.tc_branch_taken;
        end
        cnt_upd    = cnt_q + trdb_pkg::bcnt_t'(append);
        full_due   = take && (cnt_upd == trdb_pkg::bcnt_t'(trdb_pkg::MAP_LEN));
        discon_due = take && itype_i.nc_updiscon && in_window_i;

        full_pkt = '{fmt: trdb_pkg::PKT_BRANCH_FULL, bcnt: cnt_upd, map: map_upd,
                     iaddr: pair_i.tc.iaddr};
        // after a full packet the map starts empty
        discon_pkt = '{fmt: trdb_pkg::PKT_DISCON,
                       bcnt: full_due ? '0 : cnt_upd,
                       map: full_due ? '0 : map_upd,
                       iaddr: pair_i.nc.iaddr};

        // oldest first: slot, then full, then discon
        emit      = 1'b0;
        emit_pkt  = slot_q;
        slot_load = 1'b0;
        if (slot_valid_q) begin
            // map was just cleared, so only a discon can be new here
            emit      = 1'b1;
            slot_load = discon_due;
        end else if (full_due) begin
            emit      = 1'b1;
            emit_pkt  = full_pkt;
            slot_load = discon_due;
        end else if (discon_due) begin
            emit      = 1'b1;
            emit_pkt  = discon_pkt;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= 1'b0;
            map_q        <= '0;
            cnt_q        <= '0;
            slot_valid_q <= 1'b0;
            pkt_valid_o  <= 1'b0;
        end else begin
            pkt_valid_o  <= emit;
            slot_valid_q <= slot_load;
            if (take) begin
                pending_q <= itype_i.nc_branch && in_window_i;
                // any packet empties the map
                if (full_due || discon_due) begin
                    map_q <= '0;
                    cnt_q <= '0;
                end else begin
                    map_q <= map_upd;
                    cnt_q <= cnt_upd;
                end
            end
        end
    end

    // packet payload
    always_ff @(posedge clk_i) begin
        if (emit) begin
            pkt_o <= emit_pkt;
        end
        if (slot_load) begin
            slot_q <= discon_pkt;
        end
    end

    // one pulse per packet for the counter
    assign pkt_emitted_o = pkt_valid_o;

endmodule

// File: verilog/trdb_addr_filter.sv
// trace window check on the nc address, both bounds inclusive
// a window with lo above hi filters everything out
`timescale 1ns/1ps

module trdb_addr_filter (
    input  trdb_pkg::pair_t  pair_i,
    input  trdb_pkg::iaddr_t win_lo_i,
    input  trdb_pkg::iaddr_t win_hi_i,
    output logic             in_window_o
);

    logic above_lo;
    logic below_hi;

    // unsigned compares
    assign above_lo = pair_i.nc.iaddr >= win_lo_i;
    assign below_hi = pair_i.nc.iaddr <= win_hi_i;

    // empty nc slot never counts
    assign in_window_o = pair_i.nc_ready && above_lo && below_hi;

endmodule

// File: verilog/trdb_itype_detector.sv
// classifies the nc instruction and the control flow from tc to nc
// compressed jumps are expected to arrive decompressed
`timescale 1ns/1ps

module trdb_itype_detector (
    input  trdb_pkg::pair_t  pair_i,
    output trdb_pkg::itype_t itype_o
);

    trdb_pkg::insn_t  insn;
    trdb_pkg::iaddr_t seq_addr;
    logic             both_ready;
    logic             same_instr;
    logic             is_branch;
    logic             is_jalr;

    assign insn       = pair_i.nc.insn;
    assign both_ready = pair_i.tc_ready && pair_i.nc_ready;
    // repeated address, e.g. a retired instruction reported twice
    assign same_instr = both_ready && (pair_i.tc.iaddr == pair_i.nc.iaddr);

    // mask/match against all conditional branch encodings
    assign is_branch =
        ((insn & trdb_pkg::MASK_BEQ)      == trdb_pkg::MATCH_BEQ)      ||
        ((insn & trdb_pkg::MASK_BNE)      == trdb_pkg::MATCH_BNE)      ||
        ((insn & trdb_pkg::MASK_BLT)      == trdb_pkg::MATCH_BLT)      ||
        ((insn & trdb_pkg::MASK_BGE)      == trdb_pkg::MATCH_BGE)      ||
        ((insn & trdb_pkg::MASK_BLTU)     == trdb_pkg::MATCH_BLTU)     ||
        ((insn & trdb_pkg::MASK_BGEU)     == trdb_pkg::MATCH_BGEU)     ||
        ((insn & trdb_pkg::MASK_P_BEQIMM) == trdb_pkg::MATCH_P_BEQIMM) ||
        ((insn & trdb_pkg::MASK_P_BNEIMM) == trdb_pkg::MATCH_P_BNEIMM) ||
        ((insn & trdb_pkg::MASK_C_BEQZ)   == trdb_pkg::MATCH_C_BEQZ)   ||
        ((insn & trdb_pkg::MASK_C_BNEZ)   == trdb_pkg::MATCH_C_BNEZ);

    assign is_jalr = (insn & trdb_pkg::MASK_JALR) == trdb_pkg::MATCH_JALR;

    // next sequential address after tc
    assign seq_addr = pair_i.tc.iaddr + (pair_i.tc.compressed ? 32'd2 : 32'd4);

    assign itype_o.nc_branch       = is_branch && pair_i.nc_ready && !same_instr;
    assign itype_o.tc_branch_taken = both_ready && !same_instr && (pair_i.nc.iaddr != seq_addr);
    // uninferable: target held in a register, or trap
    assign itype_o.nc_updiscon     = (is_jalr || pair_i.nc.exception)
                                     && pair_i.nc_ready && !same_instr;

endmodule

// File: verilog/trdb_instr_pair.sv
// keeps the last two retired instructions, no back-pressure on the core side
// input while disabled is dropped and the slots stay empty
`timescale 1ns/1ps

module trdb_instr_pair (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               valid_i,
    input  trdb_pkg::retired_t retired_i,
    input  logic               enable_i,
    output trdb_pkg::pair_t    pair_o,
    output logic               update_o
);

    trdb_pkg::retired_t tc_q;
    trdb_pkg::retired_t nc_q;
    logic               tc_ready_q;
    logic               nc_ready_q;
    logic               accept;

    assign accept = valid_i && enable_i;

    // ready flags and update strobe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tc_ready_q <= 1'b0;
            nc_ready_q <= 1'b0;
            update_o   <= 1'b0;
        end else if (!enable_i) begin
            // empty slots, so restart gives no taken verdict
            tc_ready_q <= 1'b0;
            nc_ready_q <= 1'b0;
            update_o   <= 1'b0;
        end else begin
            update_o <= accept;
            if (accept) begin
                tc_ready_q <= nc_ready_q;
                nc_ready_q <= 1'b1;
            end
        end
    end

    // instruction payload, shifts nc into tc
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tc_q <= nc_q;
            nc_q <= retired_i;
        end
    end

    assign pair_o = '{tc: tc_q, nc: nc_q, tc_ready: tc_ready_q, nc_ready: nc_ready_q};

endmodule

// File: verilog/trdb_pkg.sv
// shared types and constants of the trace encoder
// XLEN is fixed at 32. the APB data width equals XLEN
package trdb_pkg;

    localparam int XLEN = 32;

    // meaningful widths
    typedef logic [XLEN-1:0] iaddr_t;
    typedef logic [XLEN-1:0] insn_t;

    // conditional branches
    localparam insn_t MASK_BEQ     = 32'h0000707f;
    localparam insn_t MATCH_BEQ    = 32'h00000063;
    localparam insn_t MASK_BNE     = 32'h0000707f;
    localparam insn_t MATCH_BNE    = 32'h00001063;
    localparam insn_t MASK_BLT     = 32'h0000707f;
    localparam insn_t MATCH_BLT    = 32'h00004063;
    localparam insn_t MASK_BGE     = 32'h0000707f;
    localparam insn_t MATCH_BGE    = 32'h00005063;
    localparam insn_t MASK_BLTU    = 32'h0000707f;
    localparam insn_t MATCH_BLTU   = 32'h00006063;
    localparam insn_t MASK_BGEU    = 32'h0000707f;
    localparam insn_t MATCH_BGEU   = 32'h00007063;
    // pulp immediate branches, in the funct3 slots left free by the base ISA
    localparam insn_t MASK_P_BEQIMM  = 32'h0000707f;
    localparam insn_t MATCH_P_BEQIMM = 32'h00002063;
    localparam insn_t MASK_P_BNEIMM  = 32'h0000707f;
    localparam insn_t MATCH_P_BNEIMM = 32'h00003063;
    // compressed branches, low half only
    localparam insn_t MASK_C_BEQZ  = 32'h0000e003;
    localparam insn_t MATCH_C_BEQZ = 32'h0000c001;
    localparam insn_t MASK_C_BNEZ  = 32'h0000e003;
    localparam insn_t MATCH_C_BNEZ = 32'h0000e001;
    // indirect jump
    localparam insn_t MASK_JALR    = 32'h0000707f;
    localparam insn_t MATCH_JALR   = 32'h00000067;

    // one retired instruction, 66 bits
    typedef struct packed {
        iaddr_t iaddr;
        insn_t  insn;
        logic   compressed;
        logic   exception;
    } retired_t;

    // tc is the older one, nc the newer one
    typedef struct packed {
        retired_t tc;
        retired_t nc;
        logic     tc_ready;
        logic     nc_ready;
    } pair_t;

    typedef struct packed {
        logic nc_branch;
        logic tc_branch_taken;
        logic nc_updiscon;
    } itype_t;

    localparam int MAP_LEN = 31;

    typedef logic [MAP_LEN-1:0] map_t;
    typedef logic [4:0]         bcnt_t;

    typedef enum logic [1:0] {
        PKT_BRANCH_FULL = 2'b01,
        PKT_DISCON      = 2'b10
    } pkt_fmt_e;

    typedef struct packed {
        pkt_fmt_e fmt;
        bcnt_t    bcnt;
        map_t     map;
        iaddr_t   iaddr;
    } packet_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [3:0] REG_CTRL    = 4'h0;
    localparam logic [3:0] REG_WIN_LO  = 4'h4;
    localparam logic [3:0] REG_WIN_HI  = 4'h8;
    localparam logic [3:0] REG_PKT_CNT = 4'hC;

    typedef enum logic {
        IDLE,
        ACCESS
    } apb_state_e;

endpackage
